//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [63:0] word_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  shamt_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

  // Selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

endpackage

`default_nettype wire

//--- design/pipeline_pkg.sv
`default_nettype none

package pipeline_pkg;

  // Where execute takes an operand from
  typedef enum logic [1:0] {
    FWD_REG,
    FWD_EX,
    FWD_WB
  } fwd_sel_e;

  localparam rv_isa_pkg::addr_t PC_STEP  = 64'd4;
  localparam rv_isa_pkg::addr_t RESET_PC = 64'd0;

endpackage

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                 clk,
  input  logic                 reset,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  logic                 write_en,
  input  rv_isa_pkg::reg_idx_t write_index,
  input  rv_isa_pkg::word_t    write_value,
  output rv_isa_pkg::word_t    rs1_value,
  output rv_isa_pkg::word_t    rs2_value
);

  rv_isa_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_index != '0) begin
      regs[write_index] <= write_value;
    end
  end

  // Write-first, so a read in the write cycle sees the new value
  assign rs1_value = (rs1 == '0) ? '0 :
                     (write_en && write_index == rs1) ? write_value : regs[rs1];
  assign rs2_value = (rs2 == '0) ? '0 :
                     (write_en && write_index == rs2) ? write_value : regs[rs2];

endmodule

`default_nettype wire

//--- design/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
  input  logic               clk,
  input  logic               reset,
  input  rv_isa_pkg::instr_t imem_data,
  output rv_isa_pkg::addr_t  imem_addr,
  output logic               valid,
  output rv_isa_pkg::instr_t instruction,
  output logic               is_final
);

  rv_isa_pkg::addr_t pc;
  logic              halted;

  assign imem_addr   = pc;
  assign instruction = imem_data;
  assign valid       = !halted;

  // Only fetch sees the raw word, so ebreak is flagged here
  assign is_final = valid && (imem_data == rv_isa_pkg::INSTR_EBREAK);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= pipeline_pkg::RESET_PC;
      halted <= 1'b0;
    end else if (is_final) begin
      // Counter stays on the ebreak address
      halted <= 1'b1;
    end else if (!halted) begin
      pc <= pc + pipeline_pkg::PC_STEP;
    end
  end

endmodule

`default_nettype wire

//--- design/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  rv_isa_pkg::instr_t     instruction,
  input  logic                   in_is_final,
  input  rv_isa_pkg::word_t      rs1_value,
  input  rv_isa_pkg::word_t      rs2_value,
  input  rv_isa_pkg::reg_idx_t   ex_rd,
  input  logic                   ex_write,
  input  rv_isa_pkg::reg_idx_t   wb_rd,
  input  logic                   wb_write,
  output rv_isa_pkg::reg_idx_t   rs1,
  output rv_isa_pkg::reg_idx_t   rs2,
  output logic                   valid,
  output rv_isa_pkg::alu_op_e    alu_op,
  output rv_isa_pkg::word_t      op_a,
  output rv_isa_pkg::word_t      op_b,
  output pipeline_pkg::fwd_sel_e fwd_a,
  output pipeline_pkg::fwd_sel_e fwd_b,
  output rv_isa_pkg::reg_idx_t   rd,
  output logic                   write_to_rd,
  output logic                   is_final
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  rv_isa_pkg::reg_idx_t rd_field;
  rv_isa_pkg::word_t    imm_i;
  rv_isa_pkg::word_t    imm_u;
  logic                 is_rtype;
  logic                 is_lui;
  logic                 supported;
  logic                 alt;
  rv_isa_pkg::alu_op_e  alu_op_d;

  rv_isa_pkg::reg_idx_t rs1_q;
  rv_isa_pkg::reg_idx_t rs2_q;
  logic                 rs2_used_q;

  assign opcode   = instruction[6:0];
  assign rd_field = instruction[11:7];
  assign funct3   = instruction[14:12];
  assign rs1      = instruction[19:15];
  assign rs2      = instruction[24:20];
  assign funct7   = instruction[31:25];

  assign imm_i = {{52{instruction[31]}}, instruction[31:20]};
  assign imm_u = {{32{instruction[31]}}, instruction[31:12], 12'b0};

  assign is_rtype  = (opcode == rv_isa_pkg::OPC_OP);
  assign is_lui    = (opcode == rv_isa_pkg::OPC_LUI);
  assign supported = is_rtype || is_lui || (opcode == rv_isa_pkg::OPC_OP_IMM);

  // RV64 immediate shifts keep shamt[5] in bit 25, so only funct6 counts
  assign alt = is_rtype ? (funct7 == rv_isa_pkg::FUNCT7_ALT)
                        : ((funct7 >> 1) == (rv_isa_pkg::FUNCT7_ALT >> 1));

  always_comb begin
    alu_op_d = rv_isa_pkg::ALU_ADD;
    if (is_lui) begin
      alu_op_d = rv_isa_pkg::ALU_PASS_B;
    end else begin
      case (funct3)
        rv_isa_pkg::F3_ADD_SUB:
          alu_op_d = (is_rtype && alt) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
        rv_isa_pkg::F3_SLL:  alu_op_d = rv_isa_pkg::ALU_SLL;
        rv_isa_pkg::F3_SLT:  alu_op_d = rv_isa_pkg::ALU_SLT;
        rv_isa_pkg::F3_SLTU: alu_op_d = rv_isa_pkg::ALU_SLTU;
        rv_isa_pkg::F3_XOR:  alu_op_d = rv_isa_pkg::ALU_XOR;
        rv_isa_pkg::F3_SRL_SRA:
          alu_op_d = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
        rv_isa_pkg::F3_OR:   alu_op_d = rv_isa_pkg::ALU_OR;
        rv_isa_pkg::F3_AND:  alu_op_d = rv_isa_pkg::ALU_AND;
        default:             alu_op_d = rv_isa_pkg::ALU_ADD;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid       <= 1'b0;
      write_to_rd <= 1'b0;
      is_final    <= 1'b0;
    end else begin
      valid       <= in_valid;
      write_to_rd <= in_valid && supported && (rd_field != '0);
      is_final    <= in_valid && in_is_final;
    end
  end

  always_ff @(posedge clk) begin
    alu_op     <= alu_op_d;
    op_a       <= rs1_value;
    op_b       <= is_rtype ? rs2_value : (is_lui ? imm_u : imm_i);
    rd         <= rd_field;
    rs1_q      <= rs1;
    rs2_q      <= rs2;
    rs2_used_q <= is_rtype;
  end

  // Checked against the stages ahead while this instruction executes
  // nearer stage first
  always_comb begin
    fwd_a = pipeline_pkg::FWD_REG;
    if (ex_write && ex_rd == rs1_q) begin
      fwd_a = pipeline_pkg::FWD_EX;
    end else if (wb_write && wb_rd == rs1_q) begin
      fwd_a = pipeline_pkg::FWD_WB;
    end
    fwd_b = pipeline_pkg::FWD_REG;
    if (rs2_used_q && ex_write && ex_rd == rs2_q) begin
      fwd_b = pipeline_pkg::FWD_EX;
    end else if (rs2_used_q && wb_write && wb_rd == rs2_q) begin
      fwd_b = pipeline_pkg::FWD_WB;
    end
  end

endmodule

`default_nettype wire

//--- design/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  rv_isa_pkg::alu_op_e    alu_op,
  input  rv_isa_pkg::word_t      op_a,
  input  rv_isa_pkg::word_t      op_b,
  input  pipeline_pkg::fwd_sel_e fwd_a,
  input  pipeline_pkg::fwd_sel_e fwd_b,
  input  rv_isa_pkg::reg_idx_t   in_rd,
  input  logic                   in_write_to_rd,
  input  logic                   in_is_final,
  input  rv_isa_pkg::word_t      wb_value,
  output logic                   valid,
  output rv_isa_pkg::word_t      result,
  output rv_isa_pkg::reg_idx_t   rd,
  output logic                   write_to_rd,
  output logic                   is_final
);

  rv_isa_pkg::word_t  a;
  rv_isa_pkg::word_t  b;
  rv_isa_pkg::word_t  alu_result;
  rv_isa_pkg::shamt_t shamt;

  always_comb begin
    case (fwd_a)
      pipeline_pkg::FWD_EX: a = result;
      pipeline_pkg::FWD_WB: a = wb_value;
      default:              a = op_a;
    endcase
    case (fwd_b)
      pipeline_pkg::FWD_EX: b = result;
      pipeline_pkg::FWD_WB: b = wb_value;
      default:              b = op_b;
    endcase
  end

  assign shamt = b[5:0];

  always_comb begin
    case (alu_op)
      rv_isa_pkg::ALU_ADD:    alu_result = a + b;
      rv_isa_pkg::ALU_SUB:    alu_result = a - b;
      rv_isa_pkg::ALU_SLL:    alu_result = a << shamt;
      rv_isa_pkg::ALU_SLT:    alu_result = rv_isa_pkg::word_t'($signed(a) < $signed(b));
      rv_isa_pkg::ALU_SLTU:   alu_result = rv_isa_pkg::word_t'(a < b);
      rv_isa_pkg::ALU_XOR:    alu_result = a ^ b;
      rv_isa_pkg::ALU_SRL:    alu_result = a >> shamt;
      rv_isa_pkg::ALU_SRA:    alu_result = $unsigned($signed(a) >>> shamt);
      rv_isa_pkg::ALU_OR:     alu_result = a | b;
      rv_isa_pkg::ALU_AND:    alu_result = a & b;
      rv_isa_pkg::ALU_PASS_B: alu_result = b;
      default:                alu_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid       <= 1'b0;
      write_to_rd <= 1'b0;
      is_final    <= 1'b0;
    end else begin
      valid       <= in_valid;
      write_to_rd <= in_valid && in_write_to_rd;
      is_final    <= in_valid && in_is_final;
    end
  end

  always_ff @(posedge clk) begin
    result <= alu_result;
    rd     <= in_rd;
  end

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  rv_isa_pkg::word_t    in_result,
  input  rv_isa_pkg::reg_idx_t in_rd,
  input  logic                 in_write_to_rd,
  input  logic                 in_is_final,
  output logic                 reg_write_en,
  output rv_isa_pkg::reg_idx_t reg_write_index,
  output rv_isa_pkg::word_t    reg_write_value,
  output logic                 done
);

  logic valid_q;
  logic write_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      write_q <= 1'b0;
      done    <= 1'b0;
    end else begin
      valid_q <= in_valid;
      write_q <= in_write_to_rd;
      // Sticky until reset
      if (in_valid && in_is_final) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    reg_write_index <= in_rd;
    reg_write_value <= in_result;
  end

  assign reg_write_en = valid_q && write_q;

endmodule

`default_nettype wire

//--- design/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic                 clk,
  input  logic                 reset,
  input  rv_isa_pkg::instr_t   imem_data,
  output rv_isa_pkg::addr_t    imem_addr,
  output logic                 reg_write_en,
  output rv_isa_pkg::reg_idx_t reg_write_index,
  output rv_isa_pkg::word_t    reg_write_value,
  output logic                 done
);

  // Fetch outputs
  logic                   fetch_valid;
  rv_isa_pkg::instr_t     fetch_instruction;
  logic                   fetch_is_final;

  // Register file read ports
  rv_isa_pkg::reg_idx_t   rs1_idx;
  rv_isa_pkg::reg_idx_t   rs2_idx;
  rv_isa_pkg::word_t      rs1_value;
  rv_isa_pkg::word_t      rs2_value;

  // Decode outputs
  logic                   decode_valid;
  rv_isa_pkg::alu_op_e    decode_alu_op;
  rv_isa_pkg::word_t      decode_op_a;
  rv_isa_pkg::word_t      decode_op_b;
  pipeline_pkg::fwd_sel_e decode_fwd_a;
  pipeline_pkg::fwd_sel_e decode_fwd_b;
  rv_isa_pkg::reg_idx_t   decode_rd;
  logic                   decode_write_to_rd;
  logic                   decode_is_final;

  // Execute outputs
  logic                   execute_valid;
  rv_isa_pkg::word_t      execute_result;
  rv_isa_pkg::reg_idx_t   execute_rd;
  logic                   execute_write_to_rd;
  logic                   execute_is_final;

  instruction_fetch fetch_stage (
    .clk,
    .reset,
    .imem_data,
    .imem_addr,
    .valid      (fetch_valid),
    .instruction(fetch_instruction),
    .is_final   (fetch_is_final)
  );

  register_file register_table (
    .clk,
    .reset,
    .rs1        (rs1_idx),
    .rs2        (rs2_idx),
    .write_en   (reg_write_en),
    .write_index(reg_write_index),
    .write_value(reg_write_value),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value)
  );

  instruction_decode decode_stage (
    .clk,
    .reset,
    .in_valid   (fetch_valid),
    .instruction(fetch_instruction),
    .in_is_final(fetch_is_final),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value),
    .ex_rd      (execute_rd),
    .ex_write   (execute_write_to_rd),
    .wb_rd      (reg_write_index),
    .wb_write   (reg_write_en),
    .rs1        (rs1_idx),
    .rs2        (rs2_idx),
    .valid      (decode_valid),
    .alu_op     (decode_alu_op),
    .op_a       (decode_op_a),
    .op_b       (decode_op_b),
    .fwd_a      (decode_fwd_a),
    .fwd_b      (decode_fwd_b),
    .rd         (decode_rd),
    .write_to_rd(decode_write_to_rd),
    .is_final   (decode_is_final)
  );

  execute execute_stage (
    .clk,
    .reset,
    .in_valid      (decode_valid),
    .alu_op        (decode_alu_op),
    .op_a          (decode_op_a),
    .op_b          (decode_op_b),
    .fwd_a         (decode_fwd_a),
    .fwd_b         (decode_fwd_b),
    .in_rd         (decode_rd),
    .in_write_to_rd(decode_write_to_rd),
    .in_is_final   (decode_is_final),
    .wb_value      (reg_write_value),
    .valid         (execute_valid),
    .result        (execute_result),
    .rd            (execute_rd),
    .write_to_rd   (execute_write_to_rd),
    .is_final      (execute_is_final)
  );

  writeback_stage writeback (
    .clk,
    .reset,
    .in_valid       (execute_valid),
    .in_result      (execute_result),
    .in_rd          (execute_rd),
    .in_write_to_rd (execute_write_to_rd),
    .in_is_final    (execute_is_final),
    .reg_write_en,
    .reg_write_index,
    .reg_write_value,
    .done
  );

endmodule

`default_nettype wire

//--- verif/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_props (
  input logic                 clk,
  input logic                 reset,
  input rv_isa_pkg::addr_t    imem_addr,
  input logic                 reg_write_en,
  input rv_isa_pkg::reg_idx_t reg_write_index,
  input logic                 done
);

  // Sticky until the next reset
  done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
    else $error("done fell while reset was low");

  no_x0_write: assert property (@(posedge clk) disable iff (reset)
      reg_write_en |-> reg_write_index != '0)
    else $error("register write port targeted x0");

  quiet_after_done: assert property (@(posedge clk) disable iff (reset) done |-> !reg_write_en)
    else $error("register write seen after done");

  addr_frozen: assert property (@(posedge clk) disable iff (reset) done |=> $stable(imem_addr))
    else $error("fetch address moved after done");

endmodule

bind rv_core_top rv_core_props props (
  .clk            (clk),
  .reset          (reset),
  .imem_addr      (imem_addr),
  .reg_write_en   (reg_write_en),
  .reg_write_index(reg_write_index),
  .done           (done)
);

`default_nettype wire

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int NUM_ROWS   = 7;
  localparam int PROG_MAX   = 12;
  localparam int STEP_MAX   = PROG_MAX + 10;
  localparam int WATCHDOG_NS = NUM_ROWS * (PROG_MAX + 10) * 4 + NUM_ROWS * 4 * 4 + 8;

  logic                 clk = 1'b0;
  logic                 reset;
  rv_isa_pkg::instr_t   imem_data;
  rv_isa_pkg::addr_t    imem_addr;
  logic                 reg_write_en;
  rv_isa_pkg::reg_idx_t reg_write_index;
  rv_isa_pkg::word_t    reg_write_value;
  logic                 done;

  // Program table and per-instruction expected writes
  string                row_name [NUM_ROWS];
  rv_isa_pkg::instr_t   row_prog [NUM_ROWS][PROG_MAX];
  int                   row_chk  [NUM_ROWS];
  rv_isa_pkg::word_t    row_exp  [NUM_ROWS];
  logic                 exp_wen  [NUM_ROWS][PROG_MAX];
  rv_isa_pkg::reg_idx_t exp_rd   [NUM_ROWS][PROG_MAX];
  rv_isa_pkg::word_t    exp_val  [NUM_ROWS][PROG_MAX];
  rv_isa_pkg::instr_t   cur [$];
  int                   n_rows = 0;
  int                   n_pass = 0;
  int                   n_fail = 0;

  rv_core_top uut (
    .clk,
    .reset,
    .imem_data,
    .imem_addr,
    .reg_write_en,
    .reg_write_index,
    .reg_write_value,
    .done
  );

  always #2 clk = ~clk;

  function automatic rv_isa_pkg::instr_t rtype(logic [6:0] f7, logic [2:0] f3, int rd,
                                               int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_isa_pkg::OPC_OP};
  endfunction

  function automatic rv_isa_pkg::instr_t itype(logic [2:0] f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), rv_isa_pkg::OPC_OP_IMM};
  endfunction

  function automatic rv_isa_pkg::instr_t lui_word(int rd, int imm);
    return {20'(imm), 5'(rd), rv_isa_pkg::OPC_LUI};
  endfunction

  function automatic int random_imm();
    return int'($urandom_range(4095)) - 2048;
  endfunction

  function automatic int random_shamt();
    return int'($urandom_range(63));
  endfunction

  // Instruction memory, ebreak past the end of the program
  function automatic rv_isa_pkg::instr_t word_at(int r, rv_isa_pkg::addr_t addr);
    if (addr >= 64'(PROG_MAX * 4)) begin
      return rv_isa_pkg::INSTR_EBREAK;
    end
    return row_prog[r][int'(addr >> 2)];
  endfunction

  // Sequential ISA model of one program
  task automatic interpret(input int r);
    rv_isa_pkg::word_t  x [32];
    rv_isa_pkg::instr_t w;
    rv_isa_pkg::word_t  a;
    rv_isa_pkg::word_t  b;
    rv_isa_pkg::word_t  res;
    logic [5:0]         sh;
    logic               wr;
    logic               stopped;
    stopped = 1'b0;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    for (int i = 0; i < PROG_MAX; i++) begin
      w = row_prog[r][i];
      exp_wen[r][i] = 1'b0;
      exp_rd[r][i]  = '0;
      exp_val[r][i] = '0;
      if (w == rv_isa_pkg::INSTR_EBREAK) begin
        stopped = 1'b1;
      end
      if (!stopped) begin
        a   = x[w[19:15]];
        b   = (w[6:0] == rv_isa_pkg::OPC_OP) ? x[w[24:20]] : {{52{w[31]}}, w[31:20]};
        sh  = b[5:0];
        wr  = 1'b1;
        res = '0;
        if (w[6:0] == rv_isa_pkg::OPC_LUI) begin
          res = {{32{w[31]}}, w[31:12], 12'h000};
        end else if (w[6:0] == rv_isa_pkg::OPC_OP || w[6:0] == rv_isa_pkg::OPC_OP_IMM) begin
          case (w[14:12])
            rv_isa_pkg::F3_ADD_SUB: res = (w[6:0] == rv_isa_pkg::OPC_OP && w[30]) ? a - b : a + b;
            rv_isa_pkg::F3_SLL:     res = a << sh;
            rv_isa_pkg::F3_SLT:     res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            rv_isa_pkg::F3_SLTU:    res = (a < b) ? 64'd1 : 64'd0;
            rv_isa_pkg::F3_XOR:     res = a ^ b;
            rv_isa_pkg::F3_SRL_SRA: res = w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            rv_isa_pkg::F3_OR:      res = a | b;
            default:                res = a & b;
          endcase
        end else begin
          wr = 1'b0;
        end
        if (wr && w[11:7] != 5'd0) begin
          x[w[11:7]]    = res;
          exp_wen[r][i] = 1'b1;
          exp_rd[r][i]  = w[11:7];
          exp_val[r][i] = res;
        end
      end
    end
    row_exp[r] = x[row_chk[r]];
  endtask

  task automatic add_row(input string name, input int chk);
    row_name[n_rows] = name;
    row_chk[n_rows]  = chk;
    for (int i = 0; i < PROG_MAX; i++) begin
      row_prog[n_rows][i] = (i < cur.size()) ? cur[i] : rv_isa_pkg::INSTR_EBREAK;
    end
    interpret(n_rows);
    cur.delete();
    n_rows++;
  endtask

  task automatic build_table();
    cur = '{itype(rv_isa_pkg::F3_ADD_SUB, 1, 0, random_imm()),
            itype(rv_isa_pkg::F3_SLT, 2, 1, random_imm()),
            itype(rv_isa_pkg::F3_SLTU, 3, 1, random_imm()),
            itype(rv_isa_pkg::F3_XOR, 4, 1, random_imm()),
            itype(rv_isa_pkg::F3_OR, 5, 1, random_imm()),
            itype(rv_isa_pkg::F3_AND, 6, 1, random_imm())};
    add_row("imm_arith", 6);
    cur = '{lui_word(1, int'($urandom_range(1048575))),
            itype(rv_isa_pkg::F3_ADD_SUB, 1, 1, random_imm()),
            itype(rv_isa_pkg::F3_SLL, 2, 1, random_shamt()),
            itype(rv_isa_pkg::F3_SRL_SRA, 3, 1, random_shamt()),
            itype(rv_isa_pkg::F3_SRL_SRA, 4, 1, 1024 + random_shamt()),
            itype(rv_isa_pkg::F3_SRL_SRA, 5, 2, 1024 + random_shamt())};
    add_row("imm_shift_lui", 4);
    // Negative against positive, both signed and unsigned
    cur = '{itype(rv_isa_pkg::F3_ADD_SUB, 1, 0, -5),
            itype(rv_isa_pkg::F3_ADD_SUB, 2, 0, 3),
            rtype(7'd0, rv_isa_pkg::F3_ADD_SUB, 4, 1, 2),
            rtype(rv_isa_pkg::FUNCT7_ALT, rv_isa_pkg::F3_ADD_SUB, 5, 2, 1),
            rtype(7'd0, rv_isa_pkg::F3_SLL, 6, 1, 2),
            rtype(7'd0, rv_isa_pkg::F3_SLT, 7, 1, 2),
            rtype(7'd0, rv_isa_pkg::F3_SLTU, 8, 1, 2),
            rtype(7'd0, rv_isa_pkg::F3_SLT, 9, 2, 1),
            rtype(7'd0, rv_isa_pkg::F3_SLTU, 10, 2, 1)};
    add_row("reg_arith", 10);
    cur = '{lui_word(3, 32'h80000),
            itype(rv_isa_pkg::F3_ADD_SUB, 3, 3, random_imm()),
            itype(rv_isa_pkg::F3_ADD_SUB, 2, 0, 7),
            rtype(7'd0, rv_isa_pkg::F3_XOR, 9, 3, 2),
            rtype(7'd0, rv_isa_pkg::F3_SRL_SRA, 10, 3, 2),
            rtype(rv_isa_pkg::FUNCT7_ALT, rv_isa_pkg::F3_SRL_SRA, 11, 3, 2),
            rtype(7'd0, rv_isa_pkg::F3_OR, 12, 3, 2),
            rtype(7'd0, rv_isa_pkg::F3_AND, 13, 9, 3)};
    add_row("reg_logic_shift", 11);
    // Distances 1, 2 and 3 on rs1 and rs2
    cur = '{itype(rv_isa_pkg::F3_ADD_SUB, 1, 0, random_imm()),
            itype(rv_isa_pkg::F3_ADD_SUB, 2, 1, random_imm()),
            itype(rv_isa_pkg::F3_ADD_SUB, 3, 1, random_imm()),
            itype(rv_isa_pkg::F3_XOR, 4, 1, random_imm()),
            rtype(7'd0, rv_isa_pkg::F3_ADD_SUB, 5, 4, 2),
            rtype(rv_isa_pkg::FUNCT7_ALT, rv_isa_pkg::F3_ADD_SUB, 6, 0, 4),
            rtype(7'd0, rv_isa_pkg::F3_OR, 7, 2, 6),
            rtype(7'd0, rv_isa_pkg::F3_XOR, 8, 7, 5)};
    add_row("fwd_chain", 8);
    cur = '{itype(rv_isa_pkg::F3_ADD_SUB, 1, 0, 1),
            itype(rv_isa_pkg::F3_ADD_SUB, 1, 0, 2),
            itype(rv_isa_pkg::F3_ADD_SUB, 1, 0, 3),
            rtype(7'd0, rv_isa_pkg::F3_ADD_SUB, 2, 1, 1),
            rtype(7'd0, rv_isa_pkg::F3_ADD_SUB, 3, 2, 1)};
    add_row("fwd_priority", 3);
    // ld, jal and ecall are not supported and must leave x3 alone
    cur = '{itype(rv_isa_pkg::F3_ADD_SUB, 0, 0, random_imm()),
            lui_word(0, int'($urandom_range(1048575))),
            rtype(7'd0, rv_isa_pkg::F3_ADD_SUB, 1, 0, 0),
            itype(rv_isa_pkg::F3_ADD_SUB, 3, 1, 5),
            32'h1230_B183,
            32'h0040_01EF,
            32'h0000_0073,
            rtype(7'd0, rv_isa_pkg::F3_ADD_SUB, 4, 3, 0)};
    add_row("x0_unknown", 4);
  endtask

  task automatic run_row(input int r);
    rv_isa_pkg::addr_t addr_at [STEP_MAX];
    rv_isa_pkg::addr_t want_addr;
    rv_isa_pkg::word_t shadow [32];
    int                k;
    int                idx;
    int                seen;
    int                n_exp;
    int                errs;
    int                ebreak_step;
    int                done_step;
    k           = 0;
    seen        = 0;
    n_exp       = 0;
    errs        = 0;
    ebreak_step = -1;
    done_step   = -1;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    reset = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    while (k < STEP_MAX && (done_step < 0 || k <= done_step + 3)) begin
      if (reg_write_en) begin
        // Write in cycle k belongs to the word addressed in cycle k-3
        idx = (k >= 3) ? int'(addr_at[k - 3] >> 2) : -1;
        assert (done_step < 0 && idx >= 0 && idx < PROG_MAX && exp_wen[r][idx] &&
                exp_rd[r][idx] == reg_write_index) else begin
          $display("%s: write to x%0d in cycle %0d matches no instruction 3 cycles earlier",
                   row_name[r], reg_write_index, k);
          errs++;
        end
        if (idx >= 0 && idx < PROG_MAX) begin
          assert (reg_write_value == exp_val[r][idx]) else begin
            $display("Error: %s x%0d expected %h actual %h", row_name[r], reg_write_index,
                     exp_val[r][idx], reg_write_value);
            errs++;
          end
        end
        shadow[reg_write_index] = reg_write_value;
        seen++;
      end
      if (done && done_step < 0) begin
        done_step = k;
        assert (ebreak_step >= 0 && k == ebreak_step + 3) else begin
          $display("%s: done rose in cycle %0d but ebreak was addressed in cycle %0d",
                   row_name[r], k, ebreak_step);
          errs++;
        end
      end
      want_addr = (ebreak_step < 0) ? rv_isa_pkg::addr_t'(k * 4) : addr_at[ebreak_step];
      assert (imem_addr == want_addr) else begin
        $display("%s: fetch address %h in cycle %0d should be %h", row_name[r], imem_addr,
                 k, want_addr);
        errs++;
      end
      addr_at[k] = imem_addr;
      imem_data  = word_at(r, imem_addr);
      if (ebreak_step < 0 && imem_data == rv_isa_pkg::INSTR_EBREAK) begin
        ebreak_step = k;
      end
      k++;
      @(negedge clk);
    end
    for (int i = 0; i < PROG_MAX; i++) begin
      if (exp_wen[r][i]) begin
        n_exp++;
      end
    end
    assert (done_step >= 0) else begin
      $display("%s: done never rose after the program ended", row_name[r]);
      errs++;
    end
    assert (seen == n_exp) else begin
      $display("%s: %0d register writes seen where %0d were due", row_name[r], seen, n_exp);
      errs++;
    end
    assert (shadow[row_chk[r]] == row_exp[r]) else begin
      $display("Error: %s x%0d expected %h actual %h", row_name[r], row_chk[r], row_exp[r],
               shadow[row_chk[r]]);
      errs++;
    end
    if (errs == 0) begin
      n_pass++;
      $display("%s: pass", row_name[r]);
    end else begin
      n_fail++;
      $display("%s: fail with %0d errors", row_name[r], errs);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Run stopped by the watchdog after %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    reset     = 1'b1;
    imem_data = '0;
    void'($urandom(32'hedc2));
    build_table();
    @(negedge clk);
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/rv_isa_pkg.sv
design/pipeline_pkg.sv
design/register_file.sv
design/instruction_fetch.sv
design/instruction_decode.sv
design/execute.sv
design/writeback_stage.sv
design/rv_core_top.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := rv_core_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
